/* obj_rom_settings.svh */
// ----------------------------------------------------------------------------
// object graphics ROM widths
// address, data and download region sizes for the sprite PROM set
// ----------------------------------------------------------------------------
`ifndef OBJ_ROM_SETTINGS_SVH
`define OBJ_ROM_SETTINGS_SVH

// one 8K x 8 PROM
`define OBJ_AW        13
`define OBJ_DW        8

// download address is region on top of the PROM address
`define OBJ_REGION_W  2
`define OBJ_PROG_AW   15

// sixteen pixels per plane word, 2-bit colour index
`define OBJ_WORD_W    16
`define OBJ_PIX_W     2
`define OBJ_CNT_W     4

`endif

/* obj_rom_pkg.sv */
// ----------------------------------------------------------------------------
// object ROM types
// shared vector types and the shifter state encoding
// ----------------------------------------------------------------------------
`include "obj_rom_settings.svh"

package obj_rom_pkg;

    // address inside one PROM, also the object fetch address
    typedef logic [`OBJ_AW-1:0] obj_addr_t;

    // region in the top bits, PROM address below
    typedef logic [`OBJ_PROG_AW-1:0] prog_addr_t;

    typedef logic [`OBJ_DW-1:0] rom_byte_t;

    // msb is the leftmost pixel
    typedef logic [`OBJ_WORD_W-1:0] plane_word_t;

    // bit 1 from plane 1, bit 0 from plane 0
    typedef logic [`OBJ_PIX_W-1:0] obj_pixel_t;

    typedef logic [`OBJ_CNT_W-1:0] pix_count_t;

    typedef enum logic {
        st_idle,
        st_shift
    } shift_state_t;

endpackage

/* obj_fetch_if.sv */
// ----------------------------------------------------------------------------
// object fetch interface
// one fetch request and the plane word returned two cycles later
// ----------------------------------------------------------------------------
`timescale 1ns/100ps

interface obj_fetch_if import obj_rom_pkg::*; ();

    // request side
    logic        rd;
    obj_addr_t   addr;

    // return side, valid is rd two cycles late
    plane_word_t word;
    logic        valid;

    // shifter end
    modport requester (
        output rd,
        output addr,
        input  word,
        input  valid
    );

    // bank end
    modport rom (
        input  rd,
        input  addr,
        output word,
        output valid
    );

endinterface

/* obj_prom.sv */
// ----------------------------------------------------------------------------
// graphics PROM
// 8K x 8 block RAM with a download write port and a registered read
// ----------------------------------------------------------------------------
`timescale 1ns/100ps

module obj_prom import obj_rom_pkg::*; (
    input  logic      clk,
    input  logic      we,
    input  obj_addr_t wr_addr,
    input  rom_byte_t data,
    input  obj_addr_t rd_addr,
    output rom_byte_t q
);

    localparam int depth = 1 << $bits(obj_addr_t);

    // contents only come in through the download port
    rom_byte_t mem [depth];

    // write side
    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= data;
        end
    end

    // one cycle read latency
    always_ff @(posedge clk) begin
        q <= mem[rd_addr];
    end

endmodule

/* obj_plane_bank.sv */
// ----------------------------------------------------------------------------
// object plane bank
// two PROMs of one bitplane, region decode on download, registered
// 16-bit plane word two cycles after each fetch
// ----------------------------------------------------------------------------
`timescale 1ns/100ps

`include "obj_rom_settings.svh"

module obj_plane_bank import obj_rom_pkg::*; #(
    // region of the high byte, low byte sits one region above
    parameter logic [`OBJ_REGION_W-1:0] plane_region = 0
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       prog_we,
    input  prog_addr_t prog_addr,
    input  rom_byte_t  prog_data,
    obj_fetch_if.rom   fetch
);

    localparam logic [`OBJ_REGION_W-1:0] hi_region = plane_region;
    localparam logic [`OBJ_REGION_W-1:0] lo_region = plane_region + 1'b1;

    logic [`OBJ_REGION_W-1:0] region;
    obj_addr_t                wr_addr;
    logic                     hi_we;
    logic                     lo_we;
    rom_byte_t                hi_q;
    rom_byte_t                lo_q;
    logic                     rd_d1;

    // region field above the PROM address
    assign region = prog_addr[`OBJ_PROG_AW-1 -: `OBJ_REGION_W];

    // dumped ROM images store objects at the inverted address
    assign wr_addr = ~prog_addr[`OBJ_AW-1:0];

    assign hi_we = prog_we && (region == hi_region);
    assign lo_we = prog_we && (region == lo_region);

    // left half of the word
    obj_prom i_prom_hi (
        .clk     (clk),
        .we      (hi_we),
        .wr_addr (wr_addr),
        .data    (prog_data),
        .rd_addr (fetch.addr),
        .q       (hi_q)
    );

    // right half
    obj_prom i_prom_lo (
        .clk     (clk),
        .we      (lo_we),
        .wr_addr (wr_addr),
        .data    (prog_data),
        .rd_addr (fetch.addr),
        .q       (lo_q)
    );

    // rd -> prom stage -> output stage
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_d1       <= 1'b0;
            fetch.valid <= 1'b0;
        end else begin
            rd_d1       <= fetch.rd;
            fetch.valid <= rd_d1;
        end
    end

    // capture only when the prom stage holds a requested read
    always_ff @(posedge clk) begin
        if (rd_d1) begin
            fetch.word <= {hi_q, lo_q};
        end
    end

    // a returned word always belongs to a request two cycles back
    a_valid_from_rd: assert property (@(posedge clk) disable iff (reset)
        $rose(fetch.valid) |-> $past(fetch.rd, 2));

endmodule

/* obj_pixel_shifter.sv */
// ----------------------------------------------------------------------------
// object pixel shifter
// issues fetches to both plane banks and streams the returned words out
// as 2-bit pixels, one per cycle, with optional horizontal flip
// ----------------------------------------------------------------------------
`timescale 1ns/100ps

module obj_pixel_shifter import obj_rom_pkg::*; (
    input  logic           clk,
    input  logic           reset,
    input  logic           fetch,
    input  obj_addr_t      fetch_addr,
    input  logic           hflip,
    output logic           ready,
    obj_fetch_if.requester plane0,
    obj_fetch_if.requester plane1,
    output obj_pixel_t     pix,
    output logic           pix_valid
);

    localparam pix_count_t last_pix = '1;
    // three cycles of bank latency, so ask with four pixels still to go
    localparam pix_count_t early_pix = last_pix - pix_count_t'(3);
    localparam int msb = $bits(plane_word_t) - 1;

    shift_state_t state;
    pix_count_t   count;
    logic         accept;
    logic         rd_q;
    obj_addr_t    addr_q;
    logic         in_flight;
    logic         flip_req;
    logic [1:0]   flip_pipe;
    logic         word_flip;
    plane_word_t  sh0;
    plane_word_t  sh1;

    // at most one request waiting for its word
    assign ready  = !in_flight && (state == st_idle || count >= early_pix);
    assign accept = fetch && ready;

    // same request goes to both planes
    assign plane0.rd   = rd_q;
    assign plane0.addr = addr_q;
    assign plane1.rd   = rd_q;
    assign plane1.addr = addr_q;

    // request and in-flight tracking
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_q      <= 1'b0;
            in_flight <= 1'b0;
        end else begin
            rd_q <= accept;
            if (accept) begin
                in_flight <= 1'b1;
            end else if (plane0.valid) begin
                in_flight <= 1'b0;
            end
        end
    end

    // address and flip flag, flip follows the bank latency
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q   <= fetch_addr;
            flip_req <= hflip;
        end
        flip_pipe <= {flip_pipe[0], flip_req};
    end

    // load on valid, otherwise shift towards the output bit
    always_ff @(posedge clk) begin
        if (plane0.valid) begin
            sh0       <= plane0.word;
            sh1       <= plane1.word;
            word_flip <= flip_pipe[1];
        end else if (state == st_shift) begin
            if (word_flip) begin
                sh0 <= sh0 >> 1;
                sh1 <= sh1 >> 1;
            end else begin
                sh0 <= sh0 << 1;
                sh1 <= sh1 << 1;
            end
        end
    end

    // pixel counter fsm
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
            count <= '0;
        end else if (plane0.valid) begin
            // a new word follows straight on from the last pixel
            state <= st_shift;
            count <= '0;
        end else if (state == st_shift) begin
            count <= count + 1'b1;
            if (count == last_pix) begin
                state <= st_idle;
            end
        end
    end

    // flipped words leave lsb first
    assign pix = word_flip ? {sh1[0], sh0[0]} : {sh1[msb], sh0[msb]};
    assign pix_valid = (state == st_shift);

    // both banks share one request, so they must answer together
    a_planes_aligned: assert property (@(posedge clk) disable iff (reset)
        plane0.valid == plane1.valid);

    // next word lands only on the last pixel of the current one
    a_no_early_word: assert property (@(posedge clk) disable iff (reset)
        plane0.valid && state == st_shift |-> count == last_pix);

endmodule

/* obj_rom_top.sv */
// ----------------------------------------------------------------------------
// object ROM subsystem
// four downloadable sprite PROMs in two plane banks and the pixel
// shifter that turns fetched words into a 2-bit pixel stream
// ----------------------------------------------------------------------------
`timescale 1ns/100ps

module obj_rom_top import obj_rom_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    // download port
    input  logic       prog_we,
    input  prog_addr_t prog_addr,
    input  rom_byte_t  prog_data,
    // fetch request
    input  logic       fetch,
    input  obj_addr_t  fetch_addr,
    input  logic       hflip,
    output logic       ready,
    // pixel stream
    output obj_pixel_t pix,
    output logic       pix_valid
);

    obj_fetch_if plane0_if ();
    obj_fetch_if plane1_if ();

    // plane 0 lives in regions 2 and 3
    obj_plane_bank #(
        .plane_region (2)
    ) i_bank0 (
        .clk       (clk),
        .reset     (reset),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .fetch     (plane0_if.rom)
    );

    // plane 1 in regions 0 and 1
    obj_plane_bank #(
        .plane_region (0)
    ) i_bank1 (
        .clk       (clk),
        .reset     (reset),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .fetch     (plane1_if.rom)
    );

    obj_pixel_shifter i_shifter (
        .clk        (clk),
        .reset      (reset),
        .fetch      (fetch),
        .fetch_addr (fetch_addr),
        .hflip      (hflip),
        .ready      (ready),
        .plane0     (plane0_if.requester),
        .plane1     (plane1_if.requester),
        .pix        (pix),
        .pix_valid  (pix_valid)
    );

endmodule

/* tb_obj_rom.sv */
// ----------------------------------------------------------------------------
// object ROM testbench
// loads the four PROMs, streams fetched words and checks every pixel
// ----------------------------------------------------------------------------
`timescale 1ns/100ps

`include "obj_rom_settings.svh"

module tb_obj_rom import obj_rom_pkg::*; ();

    localparam int n_load = 8;
    localparam int n_fetch = 20;
    // reset plus five writes per address plus idle gaps
    localparam int load_cycles = 16 + 5 * n_load + 16;
    localparam int watchdog_cycles = n_fetch * 20 + load_cycles;

    logic        clk = 1'b0;
    logic        reset;
    logic        prog_we;
    prog_addr_t  prog_addr;
    rom_byte_t   prog_data;
    logic        fetch;
    obj_addr_t   fetch_addr;
    logic        hflip;
    logic        ready;
    obj_pixel_t  pix;
    logic        pix_valid;

    // mirror of the download image by region and download address
    rom_byte_t   ref_mem [4][1 << `OBJ_AW];
    obj_addr_t   load_addr [n_load];
    logic [31:0] lfsr = 32'h52f6;

    // expected pixels in stream order with their due edge and index
    obj_pixel_t  exp_pix_q [$];
    int          exp_due_q [$];
    int          exp_idx_q [$];
    int          cyc = 0;
    int          last_accept = -100;
    logic        exp_valid = 1'b0;
    obj_pixel_t  exp_pix = '0;
    logic        exp_ready = 1'b1;
    int          pix_expected = 0;
    int          pix_seen = 0;
    int          valid_errs = 0;
    int          pix_errs = 0;
    int          ready_errs = 0;
    int          other_errs = 0;

    obj_rom_top i_dut (
        .clk        (clk),
        .reset      (reset),
        .prog_we    (prog_we),
        .prog_addr  (prog_addr),
        .prog_data  (prog_data),
        .fetch      (fetch),
        .fetch_addr (fetch_addr),
        .hflip      (hflip),
        .ready      (ready),
        .pix        (pix),
        .pix_valid  (pix_valid)
    );

    initial begin
        forever #2 clk = ~clk;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout: pixel stream still busy after %0d cycles", watchdog_cycles);
        $display("SIMULATION FAILED");
        $finish;
    end

    // fibonacci lfsr with taps 32 22 2 1
    // one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int k = 0; k < n; k++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    // object address a reads download address ~a in all four regions
    function automatic obj_pixel_t expected_pixel(input obj_addr_t a, input logic flip,
                                                  input int i);
        obj_addr_t   d;
        plane_word_t p1;
        plane_word_t p0;
        int          pos;
        d = ~a;
        // plane 1 from regions 0 and 1 and plane 0 from regions 2 and 3
        // high byte on the left
        p1 = {ref_mem[0][d], ref_mem[1][d]};
        p0 = {ref_mem[2][d], ref_mem[3][d]};
        pos = flip ? i : 15 - i;
        return {p1[pos], p0[pos]};
    endfunction

    // accept at edge n puts pixel i at edge n+4+i
    always @(posedge clk) begin
        int   m;
        logic due;
        int   idx;
        m = cyc + 1;
        due = 1'b0;
        idx = 0;
        if (!reset && fetch && ready) begin
            for (int i = 0; i < 16; i++) begin
                exp_pix_q.push_back(expected_pixel(fetch_addr, hflip, i));
                exp_due_q.push_back(cyc + 4 + i);
                exp_idx_q.push_back(i);
            end
            last_accept = cyc;
            pix_expected <= pix_expected + 16;
        end
        if (!reset && pix_valid) begin
            pix_seen <= pix_seen + 1;
        end
        if (exp_due_q.size() > 0) begin
            if (exp_due_q[0] == m) begin
                due = 1'b1;
            end
        end
        if (due) begin
            idx = exp_idx_q[0];
            exp_pix <= exp_pix_q.pop_front();
            void'(exp_due_q.pop_front());
            void'(exp_idx_q.pop_front());
        end
        exp_valid <= due;
        // ready with nothing in flight and at most three pixels after this one
        exp_ready <= !(m > last_accept && m <= last_accept + 3) && (!due || idx >= 12);
        cyc <= cyc + 1;
    end

    a_pix_valid: assert property (@(posedge clk) disable iff (reset)
        pix_valid == exp_valid)
        else begin
            valid_errs++;
            $display("Error: pix_valid expected %h actual %h",
                     $sampled(exp_valid), $sampled(pix_valid));
        end

    a_pix: assert property (@(posedge clk) disable iff (reset)
        pix_valid && exp_valid |-> pix == exp_pix)
        else begin
            pix_errs++;
            $display("Error: pix expected %h actual %h", $sampled(exp_pix), $sampled(pix));
        end

    a_ready: assert property (@(posedge clk) disable iff (reset)
        ready == exp_ready)
        else begin
            ready_errs++;
            $display("Error: ready expected %h actual %h", $sampled(exp_ready), $sampled(ready));
        end

    task automatic write_byte(input logic [1:0] region, input obj_addr_t d,
                              input rom_byte_t b);
        @(posedge clk);
        prog_we   <= 1'b1;
        prog_addr <= {region, d};
        prog_data <= b;
        ref_mem[region][d] = b;
    endtask

    // hold the request until an edge sees ready
    task automatic issue_fetch(input obj_addr_t a, input logic flip);
        fetch      <= 1'b1;
        fetch_addr <= a;
        hflip      <= flip;
        do @(posedge clk); while (!ready);
    endtask

    task automatic wait_drained();
        do @(posedge clk); while (pix_seen < pix_expected);
    endtask

    initial begin
        reset      = 1'b1;
        prog_we    = 1'b0;
        prog_addr  = '0;
        prog_data  = '0;
        fetch      = 1'b0;
        fetch_addr = '0;
        hflip      = 1'b0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        repeat (4) @(posedge clk);
        // same download address in all four regions
        for (int i = 0; i < n_load; i++) begin
            load_addr[i] = obj_addr_t'(rand_bits(13));
            for (int r = 0; r < 4; r++) begin
                write_byte(2'(r), load_addr[i], rom_byte_t'(rand_bits(8)));
            end
        end
        @(posedge clk);
        prog_we <= 1'b0;
        // one word plain and then flipped
        issue_fetch(~load_addr[0], 1'b0);
        fetch <= 1'b0;
        wait_drained();
        issue_fetch(~load_addr[0], 1'b1);
        fetch <= 1'b0;
        wait_drained();
        // back to back requests that wait out ready low
        for (int i = 0; i < 8; i++) begin
            issue_fetch(~load_addr[int'(rand_bits(3))], rand_bits(1) != 0);
        end
        fetch <= 1'b0;
        wait_drained();
        // a one-cycle request in mid stream must be dropped
        issue_fetch(~load_addr[1], 1'b0);
        fetch <= 1'b0;
        do @(posedge clk); while (!pix_valid);
        fetch      <= 1'b1;
        fetch_addr <= ~load_addr[2];
        @(posedge clk);
        fetch <= 1'b0;
        wait_drained();
        // rewrite region 1 only
        for (int i = 0; i < n_load; i++) begin
            write_byte(2'd1, load_addr[i], rom_byte_t'(rand_bits(8)));
        end
        @(posedge clk);
        prog_we <= 1'b0;
        for (int i = 0; i < n_load; i++) begin
            issue_fetch(~load_addr[i], 1'b0);
            fetch <= 1'b0;
            wait_drained();
        end
        repeat (4) @(posedge clk);
        a_all_pixels: assert (pix_seen == pix_expected)
            else begin
                other_errs++;
                $display("pixel count mismatch: %0d seen, %0d expected", pix_seen,
                         pix_expected);
            end
        $display("errors: pix_valid %0d, pix %0d, ready %0d, other %0d",
                 valid_errs, pix_errs, ready_errs, other_errs);
        if (valid_errs + pix_errs + ready_errs + other_errs == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* all.f */
+incdir+.
obj_rom_pkg.sv
obj_fetch_if.sv
obj_prom.sv
obj_plane_bank.sv
obj_pixel_shifter.sv
obj_rom_top.sv
tb_obj_rom.sv

/* run.sh */
#!/bin/sh
# compile and run the object ROM testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module tb_obj_rom -o sim_tb

./obj_dir/sim_tb | tee sim.log

# the log decides pass or fail
grep -q '^SIMULATION PASSED$' sim.log
